// ==== dv/tb_tk1_core.sv ====
// Testbench top: clock, reset, seeded random bus and fetch stimulus, DUT, checker and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_tk1_core
  import tk1_pkg::*;
();

  localparam int          CLK_PERIOD      = 40;
  localparam int          RESET_CYCLES    = 8;
  localparam int          DIRECTED_CYCLES = 50;
  localparam int          RAND1_CYCLES    = 250;
  localparam int          RAND2_CYCLES    = 300;
  localparam int          RAND3_CYCLES    = 200;
  localparam int          TOTAL_CYCLES    = 5 * (RESET_CYCLES + 1) + DIRECTED_CYCLES +
                                            RAND1_CYCLES + RAND2_CYCLES + RAND3_CYCLES;
  localparam int          TIMEOUT_CYCLES  = TOTAL_CYCLES + 100;
  localparam logic [31:0] RAND_SEED       = 32'he027_8867;

  // Firmware entry points and monitor window used by the stimulus
  localparam logic [31:0] SYSCALL_PC = 32'h0000_0100;
  localparam logic [31:0] HASH_PC    = 32'h0000_0200;
  localparam logic [31:0] WIN_FIRST  = 32'h4000_1000;
  localparam logic [31:0] WIN_LAST   = 32'h4000_10ff;

  localparam logic [7:0] ADDR_TABLE [16] = '{
    ADDR_NAME0, ADDR_NAME1, ADDR_VERSION, ADDR_SYSTEM_MODE,
    ADDR_LED, ADDR_GPIO, ADDR_APP_START, ADDR_APP_SIZE,
    ADDR_HASH_ENTRY, ADDR_SYSCALL_ENTRY, ADDR_CDI_FIRST, ADDR_CDI_FIRST,
    ADDR_MON_CTRL, ADDR_MON_FIRST, ADDR_MON_LAST, 8'h05
  };

  logic        clk = 1'b0;
  logic        reset_n;
  logic        cpu_trap;
  logic [31:0] cpu_addr;
  logic        cpu_instr;
  logic        cpu_valid;
  logic        system_mode;
  logic        force_trap;
  logic        led_r;
  logic        led_g;
  logic        led_b;
  logic        gpio1;
  logic        gpio2;
  logic        gpio3;
  logic        gpio4;
  logic        cs;
  logic        we;
  logic [7:0]  address;
  logic [31:0] write_data;
  logic [31:0] read_data;
  logic        ready;
  int          bus_errors;
  int          mon_errors;
  int          io_errors;
  int          cycle_count;

  always #(CLK_PERIOD / 2) clk = ~clk;

  tk1_core i_tk1_core (.*);

  tk1_checker i_checker (.*);

  // ----------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------
  task automatic drive_cycle(input logic bus_cs, input logic bus_we, input logic [7:0] bus_addr,
                             input logic [31:0] bus_data, input logic fetch_valid,
                             input logic [31:0] fetch_pc);
    @(posedge clk);
    cs         <= bus_cs;
    we         <= bus_we;
    address    <= bus_addr;
    write_data <= bus_data;
    cpu_valid  <= fetch_valid;
    cpu_instr  <= fetch_valid;
    cpu_addr   <= fetch_pc;
  endtask

  task automatic bus_write(input logic [7:0] a, input logic [31:0] d);
    drive_cycle(1'b1, 1'b1, a, d, 1'b0, 32'h0);
  endtask

  task automatic bus_read(input logic [7:0] a);
    drive_cycle(1'b1, 1'b0, a, 32'h0, 1'b0, 32'h0);
  endtask

  task automatic fetch_at(input logic [31:0] pc);
    drive_cycle(1'b0, 1'b0, 8'h00, 32'h0, 1'b1, pc);
  endtask

  task automatic apply_reset(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      drive_cycle(1'b0, 1'b0, 8'h00, 32'h0, 1'b0, 32'h0);
      reset_n <= 1'b0;
    end
    drive_cycle(1'b0, 1'b0, 8'h00, 32'h0, 1'b0, 32'h0);
    reset_n <= 1'b1;
  endtask

  function automatic logic [7:0] pick_address(input bit allow_ctrl);
    logic [31:0] r;
    logic [7:0]  a;
    r = $urandom;
    a = ADDR_TABLE[r[3:0]];
    if (a == ADDR_CDI_FIRST) a = a | {5'h0, r[6:4]};
    if (!allow_ctrl && (a == ADDR_MON_CTRL)) a = ADDR_MON_FIRST;
    return a;
  endfunction

  // Biased toward entries, the ROM edge, fw RAM and the window
  function automatic logic [31:0] pick_fetch_addr();
    logic [31:0] r;
    logic [31:0] v;
    logic [31:0] pc;
    r = $urandom;
    v = $urandom;
    case (r[3:0])
      4'd0, 4'd1:   pc = SYSCALL_PC;
      4'd2, 4'd3:   pc = HASH_PC;
      4'd4:         pc = FW_ROM_LAST;
      4'd5:         pc = FW_ROM_LAST + 32'd1;
      4'd6:         pc = {19'h0, v[12:0]};
      4'd7:         pc = FW_RAM_FIRST | {21'h0, v[10:0]};
      4'd8, 4'd9:   pc = WIN_FIRST + {23'h0, v[8:0]};
      4'd10, 4'd11: pc = 32'h4000_0000 | {15'h0, v[16:0]};
      4'd12:        pc = 32'h4000_0000 | {2'h0, v[29:0]};
      4'd13:        pc = v;
      default:      pc = SYSCALL_PC;
    endcase
    return pc;
  endfunction

  task automatic random_cycles(input int cycles, input bit allow_ctrl);
    logic [31:0] r;
    logic [7:0]  a;
    logic [31:0] d;
    for (int i = 0; i < cycles; i++) begin
      r = $urandom;
      a = pick_address(allow_ctrl);
      d = $urandom;
      if (((a == ADDR_HASH_ENTRY) || (a == ADDR_SYSCALL_ENTRY)) && (r[8:7] != 2'b00))
        d = r[9] ? SYSCALL_PC : HASH_PC;
      if ((a == ADDR_MON_FIRST) && r[9]) d = WIN_FIRST;
      if ((a == ADDR_MON_LAST) && r[9]) d = WIN_LAST;
      @(posedge clk);
      cs         <= (r[1:0] != 2'b00);
      we         <= r[2];
      address    <= a;
      write_data <= d;
      cpu_valid  <= (r[4:3] != 2'b00);
      cpu_instr  <= r[5] | r[6];
      cpu_addr   <= pick_fetch_addr();
      if (r[15:12] == 4'h0) cpu_trap <= ~cpu_trap;
      if (r[17:16] == 2'b00) gpio1 <= r[18];
      if (r[20:19] == 2'b00) gpio2 <= r[21];
    end
  endtask

  task automatic setup_entries();
    bus_write(ADDR_SYSCALL_ENTRY, SYSCALL_PC);
    bus_write(ADDR_HASH_ENTRY, HASH_PC);
    bus_write(ADDR_MON_FIRST, WIN_FIRST);
    bus_write(ADDR_MON_LAST, WIN_LAST);
    bus_read(ADDR_SYSCALL_ENTRY);
    bus_read(ADDR_HASH_ENTRY);
  endtask

  // App mode refuses the write, syscall entry lets it through
  task automatic privilege_check();
    fetch_at(32'h4000_0040);
    bus_write(ADDR_APP_START, 32'hdead_beef);
    bus_read(ADDR_APP_START);
    bus_read(ADDR_SYSTEM_MODE);
    fetch_at(SYSCALL_PC);
    bus_write(ADDR_APP_START, 32'h1234_5678);
    bus_read(ADDR_APP_START);
  endtask

  // Fresh reset, then one access that breaks a single monitor rule
  task automatic trap_after_reset(input logic [31:0] pc, input logic instr, input bit from_app);
    apply_reset(RESET_CYCLES);
    if (from_app) fetch_at(32'h4000_0040);
    @(posedge clk);
    cpu_valid <= 1'b1;
    cpu_instr <= instr;
    cpu_addr  <= pc;
    drive_cycle(1'b0, 1'b0, 8'h00, 32'h0, 1'b0, 32'h0);
  endtask

  // Window written before the lock traps and later writes leave it in place
  task automatic lock_window();
    bus_write(ADDR_MON_FIRST, WIN_FIRST);
    bus_write(ADDR_MON_LAST, WIN_LAST);
    bus_write(ADDR_MON_CTRL, 32'h0);
    bus_write(ADDR_MON_FIRST, 32'h0);
    bus_write(ADDR_MON_LAST, 32'hffff_ffff);
    fetch_at(32'h4000_0040);
    fetch_at(WIN_FIRST + 32'h10);
  endtask

  task automatic print_counts();
    $display("Error counts: bus %0d, monitor %0d, led/gpio %0d",
             bus_errors, mon_errors, io_errors);
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    reset_n    = 1'b0;
    cpu_trap   = 1'b0;
    cpu_addr   = 32'h0;
    cpu_instr  = 1'b0;
    cpu_valid  = 1'b0;
    gpio1      = 1'b0;
    gpio2      = 1'b0;
    cs         = 1'b0;
    we         = 1'b0;
    address    = 8'h00;
    write_data = 32'h0;
    void'($urandom(RAND_SEED));
    apply_reset(RESET_CYCLES);
    bus_read(ADDR_NAME0);
    bus_read(ADDR_NAME1);
    bus_read(ADDR_VERSION);
    setup_entries();
    privilege_check();
    random_cycles(RAND1_CYCLES, 1'b0);
    random_cycles(RAND2_CYCLES, 1'b1);
    // Each trap rule on its own, starting from a cleared trap
    trap_after_reset(32'h4002_0000, 1'b0, 1'b0);
    trap_after_reset(FW_RAM_FIRST + 32'h10, 1'b1, 1'b0);
    trap_after_reset(32'h0000_0400, 1'b1, 1'b1);
    apply_reset(RESET_CYCLES);
    setup_entries();
    lock_window();
    random_cycles(RAND3_CYCLES, 1'b1);
    repeat (4) drive_cycle(1'b0, 1'b0, 8'h00, 32'h0, 1'b0, 32'h0);
    // One more edge so the last falling-edge compare is counted
    @(posedge clk);
    print_counts();
    if ((bus_errors + mon_errors + io_errors) == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: stimulus still running after %0d cycles", cycle_count);
    print_counts();
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/tk1_checker.sv ====
// Module tk1_checker: reference model of registers, mode, trap and blink with per-cycle compares
`timescale 1ns/1ps
`default_nettype none

module tk1_checker
  import tk1_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        cs,
  input  logic        we,
  input  logic [7:0]  address,
  input  logic [31:0] write_data,
  input  logic [31:0] read_data,
  input  logic        ready,
  input  logic        cpu_trap,
  input  logic [31:0] cpu_addr,
  input  logic        cpu_instr,
  input  logic        cpu_valid,
  input  logic        system_mode,
  input  logic        force_trap,
  input  logic        led_r,
  input  logic        led_g,
  input  logic        led_b,
  input  logic        gpio1,
  input  logic        gpio2,
  input  logic        gpio3,
  input  logic        gpio4,
  output int          bus_errors,
  output int          mon_errors,
  output int          io_errors
);

  int bus_cnt = 0;
  int mon_cnt = 0;
  int io_cnt = 0;
  // Set once the model has seen a reset cycle
  bit primed = 1'b0;

  logic [31:0]                mdl_app_start;
  logic [31:0]                mdl_app_size;
  logic [31:0]                mdl_hash;
  logic [31:0]                mdl_syscall;
  logic [31:0]                mdl_cdi [CDI_WORDS];
  logic                       mdl_mon_en;
  logic [31:0]                mdl_mon_first;
  logic [31:0]                mdl_mon_last;
  logic [2:0]                 mdl_led;
  logic                       mdl_gpio3;
  logic                       mdl_gpio4;
  logic [1:0]                 mdl_sync1;
  logic [1:0]                 mdl_sync2;
  logic                       mdl_mode;
  logic                       mdl_rom_exec;
  logic                       mdl_trap;
  logic [TRAP_BLINK_BITS-1:0] mdl_blink;
  logic                       mdl_red;

  assign bus_errors = bus_cnt;
  assign mon_errors = mon_cnt;
  assign io_errors  = io_cnt;

  function automatic bit values_differ(input string name, input logic [31:0] got,
                                       input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s expected 0x%h got 0x%h at %0t ns", name, exp, got, $time);
      return 1'b1;
    end
    return 1'b0;
  endfunction

  // ----------------------------------------------------------
  // Expected read data for the access on the bus now
  // ----------------------------------------------------------
  function automatic logic [31:0] expected_read();
    logic [31:0] v;
    v = 32'h0;
    if (cs && !we) begin
      if ((address >= ADDR_CDI_FIRST) && (address <= ADDR_CDI_LAST)) begin
        v = mdl_cdi[address[2:0]];
      end else begin
        case (address)
          ADDR_NAME0:         v = TK1_NAME0;
          ADDR_NAME1:         v = TK1_NAME1;
          ADDR_VERSION:       v = TK1_VERSION;
          ADDR_SYSTEM_MODE:   v = {32{mdl_mode}};
          ADDR_LED:           v = {29'h0, mdl_led};
          ADDR_GPIO:          v = {28'h0, mdl_gpio4, mdl_gpio3, mdl_sync2[1], mdl_sync1[1]};
          ADDR_APP_START:     v = mdl_app_start;
          ADDR_APP_SIZE:      v = mdl_app_size;
          ADDR_HASH_ENTRY:    v = mdl_hash;
          ADDR_SYSCALL_ENTRY: v = mdl_syscall;
          // Monitor registers and holes read as zero
          default:            v = 32'h0;
        endcase
      end
    end
    return v;
  endfunction

  task automatic compare_outputs();
    logic [2:0] led_exp;
    led_exp = cpu_trap ? {mdl_red, 2'b00} : mdl_led;
    if (values_differ("ready", {31'h0, ready}, {31'h0, cs})) bus_cnt++;
    if (values_differ($sformatf("read_data @0x%h", address), read_data, expected_read()))
      bus_cnt++;
    if (values_differ("system_mode", {31'h0, system_mode}, {31'h0, mdl_mode})) mon_cnt++;
    if (values_differ("force_trap", {31'h0, force_trap}, {31'h0, mdl_trap})) mon_cnt++;
    if (values_differ("{led_r,led_g,led_b}", {29'h0, led_r, led_g, led_b}, {29'h0, led_exp}))
      io_cnt++;
    if (values_differ("{gpio4,gpio3}", {30'h0, gpio4, gpio3}, {30'h0, mdl_gpio4, mdl_gpio3}))
      io_cnt++;
  endtask

  // ----------------------------------------------------------
  // Next state, as the DUT will have it after the coming edge
  // ----------------------------------------------------------
  task automatic step_model();
    logic        fetch;
    logic        priv_ok;
    logic [31:0] pc;
    if (!reset_n) begin
      mdl_app_start = 32'h0;
      mdl_app_size  = APP_SIZE_RESET;
      mdl_hash      = ILLEGAL_ADDR;
      mdl_syscall   = ILLEGAL_ADDR;
      for (int i = 0; i < CDI_WORDS; i++) begin
        mdl_cdi[i] = 32'h0;
      end
      mdl_mon_en    = 1'b0;
      mdl_mon_first = 32'h0;
      mdl_mon_last  = 32'h0;
      mdl_led       = LED_RESET;
      mdl_gpio3     = 1'b0;
      mdl_gpio4     = 1'b0;
      mdl_sync1     = 2'b00;
      mdl_sync2     = 2'b00;
      mdl_mode      = 1'b0;
      mdl_rom_exec  = 1'b1;
      mdl_trap      = 1'b0;
      mdl_blink     = '0;
      mdl_red       = 1'b0;
      primed        = 1'b1;
    end else begin
      fetch   = cpu_valid && cpu_instr;
      pc      = cpu_addr;
      priv_ok = !mdl_mode;
      // Violations are judged against the configuration before this edge
      if (cpu_valid && (pc[31:30] == 2'b01) && (pc[29:17] != 13'h0)) mdl_trap = 1'b1;
      if (fetch) begin
        if ((pc >= FW_RAM_FIRST) && (pc <= FW_RAM_LAST)) mdl_trap = 1'b1;
        if (!mdl_rom_exec && (pc <= FW_ROM_LAST) && (pc != mdl_syscall) && (pc != mdl_hash))
          mdl_trap = 1'b1;
        if (mdl_mon_en && (pc >= mdl_mon_first) && (pc <= mdl_mon_last)) mdl_trap = 1'b1;
        if (pc == mdl_syscall) begin
          mdl_mode     = 1'b0;
          mdl_rom_exec = 1'b1;
        end
        if (pc == mdl_hash) mdl_rom_exec = 1'b1;
        if (pc > FW_ROM_LAST) begin
          mdl_mode     = 1'b1;
          mdl_rom_exec = 1'b0;
        end
      end
      if (mdl_blink == '0) mdl_red = ~mdl_red;
      mdl_blink = mdl_blink + TRAP_BLINK_BITS'(1);
      mdl_sync1 = {mdl_sync1[0], gpio1};
      mdl_sync2 = {mdl_sync2[0], gpio2};
      if (cs && we) begin
        if ((address >= ADDR_CDI_FIRST) && (address <= ADDR_CDI_LAST)) begin
          if (priv_ok) mdl_cdi[address[2:0]] = write_data;
        end else begin
          case (address)
            ADDR_LED: mdl_led = write_data[2:0];
            ADDR_GPIO: begin
              mdl_gpio3 = write_data[2];
              mdl_gpio4 = write_data[3];
            end
            ADDR_APP_START:     if (priv_ok) mdl_app_start = write_data;
            ADDR_APP_SIZE:      if (priv_ok) mdl_app_size = write_data;
            ADDR_HASH_ENTRY:    if (priv_ok) mdl_hash = write_data;
            ADDR_SYSCALL_ENTRY: if (priv_ok) mdl_syscall = write_data;
            ADDR_MON_CTRL:      mdl_mon_en = 1'b1;
            ADDR_MON_FIRST:     if (!mdl_mon_en) mdl_mon_first = write_data;
            ADDR_MON_LAST:      if (!mdl_mon_en) mdl_mon_last = write_data;
            default: ;
          endcase
        end
      end
    end
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (primed) begin
      compare_outputs();
    end
    step_model();
  end

endmodule

`default_nettype wire

// ==== hdl/tk1_bus_decode.sv ====
// Module tk1_bus_decode: address decode, privilege gating of writes and read data mux
`timescale 1ns/1ps
`default_nettype none

module tk1_bus_decode
  import tk1_pkg::*;
(
  input  logic        cs,
  input  logic        we,
  input  logic [7:0]  address,
  input  logic [31:0] write_data,
  input  logic        system_mode,
  input  logic [31:0] cfg_rdata,
  input  logic [31:0] io_rdata,
  tk1_reg_if.decoder  regs,
  output logic [31:0] read_data,
  output logic        ready
);

  reg_sel_e    sel;
  logic        privileged;
  logic [31:0] rdata;

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------
  always_comb begin
    sel = SEL_NONE;
    case (address)
      ADDR_NAME0:         sel = SEL_NAME0;
      ADDR_NAME1:         sel = SEL_NAME1;
      ADDR_VERSION:       sel = SEL_VERSION;
      ADDR_SYSTEM_MODE:   sel = SEL_MODE;
      ADDR_LED:           sel = SEL_LED;
      ADDR_GPIO:          sel = SEL_GPIO;
      ADDR_APP_START:     sel = SEL_APP_START;
      ADDR_APP_SIZE:      sel = SEL_APP_SIZE;
      ADDR_HASH_ENTRY:    sel = SEL_HASH;
      ADDR_SYSCALL_ENTRY: sel = SEL_SYSCALL;
      ADDR_MON_CTRL:      sel = SEL_MON_CTRL;
      ADDR_MON_FIRST:     sel = SEL_MON_FIRST;
      ADDR_MON_LAST:      sel = SEL_MON_LAST;
      default: begin
        if ((address >= ADDR_CDI_FIRST) && (address <= ADDR_CDI_LAST)) begin
          sel = SEL_CDI;
        end
      end
    endcase
  end

  // Registers that only firmware mode may change
  always_comb begin
    case (sel)
      SEL_APP_START,
      SEL_APP_SIZE,
      SEL_HASH,
      SEL_SYSCALL,
      SEL_CDI: privileged = 1'b1;
      default: privileged = 1'b0;
    endcase
  end

  assign regs.sel   = sel;
  assign regs.wr    = cs && we && !(privileged && system_mode);
  assign regs.widx  = address[2:0];
  assign regs.wdata = write_data;

  // ----------------------------------------------------------
  // Read data
  // ----------------------------------------------------------
  always_comb begin
    rdata = 32'h0;
    if (cs && !we) begin
      case (sel)
        SEL_NAME0:   rdata = TK1_NAME0;
        SEL_NAME1:   rdata = TK1_NAME1;
        SEL_VERSION: rdata = TK1_VERSION;
        SEL_MODE:    rdata = {32{system_mode}};
        SEL_LED,
        SEL_GPIO:    rdata = io_rdata;
        SEL_NONE:    rdata = 32'h0;
        // All remaining selections live in the config block
        default:     rdata = cfg_rdata;
      endcase
    end
  end

  assign read_data = rdata;
  // No wait states
  assign ready     = cs;

endmodule

`default_nettype wire

// ==== hdl/tk1_cfg_regs.sv ====
// Module tk1_cfg_regs: app start and size, entry addresses, CDI store and monitor window
`timescale 1ns/1ps
`default_nettype none

module tk1_cfg_regs
  import tk1_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  tk1_reg_if.block    regs,
  output logic [31:0] cfg_rdata,
  output exec_cfg_t   exec_cfg
);

  logic [31:0] app_start;
  logic [31:0] app_size;
  logic [31:0] hash_entry;
  logic [31:0] syscall_entry;
  logic [31:0] cdi_mem [CDI_WORDS];

  logic        mon_en;
  logic [31:0] mon_first;
  logic [31:0] mon_last;

  // ----------------------------------------------------------
  // Register writes
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      app_start     <= 32'h0;
      app_size      <= APP_SIZE_RESET;
      hash_entry    <= ILLEGAL_ADDR;
      syscall_entry <= ILLEGAL_ADDR;
      mon_en        <= 1'b0;
      mon_first     <= 32'h0;
      mon_last      <= 32'h0;
      for (int i = 0; i < CDI_WORDS; i++) begin
        cdi_mem[i] <= 32'h0;
      end
    end else if (regs.wr) begin
      case (regs.sel)
        SEL_APP_START: app_start <= regs.wdata;
        SEL_APP_SIZE:  app_size <= regs.wdata;
        SEL_HASH:      hash_entry <= regs.wdata;
        SEL_SYSCALL:   syscall_entry <= regs.wdata;
        SEL_CDI:       cdi_mem[regs.widx] <= regs.wdata;
        // One-way enable, data is ignored
        SEL_MON_CTRL:  mon_en <= 1'b1;
        SEL_MON_FIRST: begin
          if (!mon_en) begin
            mon_first <= regs.wdata;
          end
        end
        SEL_MON_LAST: begin
          if (!mon_en) begin
            mon_last <= regs.wdata;
          end
        end
        default: ;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Read back, monitor window is write only
  // ----------------------------------------------------------
  always_comb begin
    case (regs.sel)
      SEL_APP_START: cfg_rdata = app_start;
      SEL_APP_SIZE:  cfg_rdata = app_size;
      SEL_HASH:      cfg_rdata = hash_entry;
      SEL_SYSCALL:   cfg_rdata = syscall_entry;
      SEL_CDI:       cfg_rdata = cdi_mem[regs.widx];
      default:       cfg_rdata = 32'h0;
    endcase
  end

  // To the security monitor
  assign exec_cfg.syscall_entry = syscall_entry;
  assign exec_cfg.hash_entry    = hash_entry;
  assign exec_cfg.mon_en        = mon_en;
  assign exec_cfg.mon_first     = mon_first;
  assign exec_cfg.mon_last      = mon_last;

endmodule

`default_nettype wire

// ==== hdl/tk1_core.sv ====
// Module tk1_core: control core top level joining decoder, config, monitor and LED/GPIO blocks
`timescale 1ns/1ps
`default_nettype none

module tk1_core
  import tk1_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,

  // CPU side
  input  logic        cpu_trap,
  input  logic [31:0] cpu_addr,
  input  logic        cpu_instr,
  input  logic        cpu_valid,
  output logic        system_mode,
  output logic        force_trap,

  // Board pins
  output logic        led_r,
  output logic        led_g,
  output logic        led_b,
  input  logic        gpio1,
  input  logic        gpio2,
  output logic        gpio3,
  output logic        gpio4,

  // Register bus
  input  logic        cs,
  input  logic        we,
  input  logic [7:0]  address,
  input  logic [31:0] write_data,
  output logic [31:0] read_data,
  output logic        ready
);

  logic [31:0] cfg_rdata;
  logic [31:0] io_rdata;
  exec_cfg_t   exec_cfg;

  tk1_reg_if i_reg_if ();

  // ----------------------------------------------------------
  // Blocks
  // ----------------------------------------------------------
  tk1_bus_decode i_bus_decode (
    .cs          (cs),
    .we          (we),
    .address     (address),
    .write_data  (write_data),
    .system_mode (system_mode),
    .cfg_rdata   (cfg_rdata),
    .io_rdata    (io_rdata),
    .regs        (i_reg_if.decoder),
    .read_data   (read_data),
    .ready       (ready)
  );

  tk1_cfg_regs i_cfg_regs (
    .clk       (clk),
    .reset_n   (reset_n),
    .regs      (i_reg_if.block),
    .cfg_rdata (cfg_rdata),
    .exec_cfg  (exec_cfg)
  );

  tk1_exec_monitor i_exec_monitor (
    .clk         (clk),
    .reset_n     (reset_n),
    .cpu_addr    (cpu_addr),
    .cpu_instr   (cpu_instr),
    .cpu_valid   (cpu_valid),
    .exec_cfg    (exec_cfg),
    .system_mode (system_mode),
    .force_trap  (force_trap)
  );

  tk1_led_gpio i_led_gpio (
    .clk      (clk),
    .reset_n  (reset_n),
    .cpu_trap (cpu_trap),
    .gpio1    (gpio1),
    .gpio2    (gpio2),
    .regs     (i_reg_if.block),
    .io_rdata (io_rdata),
    .led_r    (led_r),
    .led_g    (led_g),
    .led_b    (led_b),
    .gpio3    (gpio3),
    .gpio4    (gpio4)
  );

endmodule

`default_nettype wire

// ==== hdl/tk1_exec_monitor.sv ====
// Module tk1_exec_monitor: system mode and ROM-executable tracking, security monitor
`timescale 1ns/1ps
`default_nettype none

module tk1_exec_monitor
  import tk1_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic [31:0] cpu_addr,
  input  logic        cpu_instr,
  input  logic        cpu_valid,
  input  exec_cfg_t   exec_cfg,
  output logic        system_mode,
  output logic        force_trap
);

  logic mode_reg;
  logic rom_exec;
  logic trap_reg;

  logic fetch;
  logic mode_we;
  logic mode_new;
  logic rom_we;
  logic rom_new;
  logic trap_set;

  assign fetch = cpu_valid && cpu_instr;

  // ----------------------------------------------------------
  // Mode tracking, later rules override earlier ones
  // ----------------------------------------------------------
  always_comb begin
    mode_we  = 1'b0;
    mode_new = 1'b0;
    rom_we   = 1'b0;
    rom_new  = 1'b0;
    if (fetch) begin
      // Syscall entry drops back into firmware mode
      if (cpu_addr == exec_cfg.syscall_entry) begin
        mode_we  = 1'b1;
        mode_new = 1'b0;
        rom_we   = 1'b1;
        rom_new  = 1'b1;
      end
      if (cpu_addr == exec_cfg.hash_entry) begin
        rom_we  = 1'b1;
        rom_new = 1'b1;
      end
      // Running above ROM means application code
      if (cpu_addr > FW_ROM_LAST) begin
        mode_we  = 1'b1;
        mode_new = 1'b1;
        rom_we   = 1'b1;
        rom_new  = 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // Security monitor
  // ----------------------------------------------------------
  always_comb begin
    trap_set = 1'b0;
    if (cpu_valid) begin
      // RAM region but beyond the physical memory size
      if ((cpu_addr[31:30] == 2'b01) && (|cpu_addr[29:17])) begin
        trap_set = 1'b1;
      end
      if (cpu_instr) begin
        if ((cpu_addr >= FW_RAM_FIRST) && (cpu_addr <= FW_RAM_LAST)) begin
          trap_set = 1'b1;
        end
        // Entry addresses stay callable while ROM is locked
        if (!rom_exec && (cpu_addr <= FW_ROM_LAST) &&
            (cpu_addr != exec_cfg.syscall_entry) &&
            (cpu_addr != exec_cfg.hash_entry)) begin
          trap_set = 1'b1;
        end
        if (exec_cfg.mon_en && (cpu_addr >= exec_cfg.mon_first) &&
            (cpu_addr <= exec_cfg.mon_last)) begin
          trap_set = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      mode_reg <= 1'b0;
      rom_exec <= 1'b1;
      trap_reg <= 1'b0;
    end else begin
      if (mode_we) begin
        mode_reg <= mode_new;
      end
      if (rom_we) begin
        rom_exec <= rom_new;
      end
      // Sticky until reset
      if (trap_set) begin
        trap_reg <= 1'b1;
      end
    end
  end

  assign system_mode = mode_reg;
  assign force_trap  = trap_reg;

endmodule

`default_nettype wire

// ==== hdl/tk1_led_gpio.sv ====
// Module tk1_led_gpio: LED register, trap blink and LED mux, GPIO synchronizers and outputs
`timescale 1ns/1ps
`default_nettype none

module tk1_led_gpio
  import tk1_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        cpu_trap,
  input  logic        gpio1,
  input  logic        gpio2,
  tk1_reg_if.block    regs,
  output logic [31:0] io_rdata,
  output logic        led_r,
  output logic        led_g,
  output logic        led_b,
  output logic        gpio3,
  output logic        gpio4
);

  logic [2:0]                 led_reg;
  logic [TRAP_BLINK_BITS-1:0] blink_ctr;
  logic                       trap_red;
  logic [2:0]                 led_mux;
  logic [1:0]                 gpio1_sync;
  logic [1:0]                 gpio2_sync;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      led_reg    <= LED_RESET;
      blink_ctr  <= '0;
      trap_red   <= 1'b0;
      gpio1_sync <= 2'h0;
      gpio2_sync <= 2'h0;
      gpio3      <= 1'b0;
      gpio4      <= 1'b0;
    end else begin
      blink_ctr  <= blink_ctr + TRAP_BLINK_BITS'(1);
      gpio1_sync <= {gpio1_sync[0], gpio1};
      gpio2_sync <= {gpio2_sync[0], gpio2};
      // Red toggles once per counter wrap
      if (blink_ctr == '0) begin
        trap_red <= ~trap_red;
      end
      if (regs.wr && (regs.sel == SEL_LED)) begin
        led_reg <= regs.wdata[2:0];
      end
      if (regs.wr && (regs.sel == SEL_GPIO)) begin
        gpio3 <= regs.wdata[2];
        gpio4 <= regs.wdata[3];
      end
    end
  end

  // ----------------------------------------------------------
  // LED pins, bit 2 is red
  // ----------------------------------------------------------
  assign led_mux = cpu_trap ? {trap_red, 2'b00} : led_reg;
  assign led_r   = led_mux[2];
  assign led_g   = led_mux[1];
  assign led_b   = led_mux[0];

  always_comb begin
    case (regs.sel)
      SEL_LED:  io_rdata = {29'h0, led_reg};
      SEL_GPIO: io_rdata = {28'h0, gpio4, gpio3, gpio2_sync[1], gpio1_sync[1]};
      default:  io_rdata = 32'h0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/tk1_pkg.sv ====
// Register map, memory-map limits, identity constants, reset values and shared types
`default_nettype none

package tk1_pkg;

  // ----------------------------------------------------------
  // Register map
  // ----------------------------------------------------------
  localparam logic [7:0] ADDR_NAME0         = 8'h00;
  localparam logic [7:0] ADDR_NAME1         = 8'h01;
  localparam logic [7:0] ADDR_VERSION       = 8'h02;
  localparam logic [7:0] ADDR_SYSTEM_MODE   = 8'h08;
  localparam logic [7:0] ADDR_LED           = 8'h09;
  localparam logic [7:0] ADDR_GPIO          = 8'h0a;
  localparam logic [7:0] ADDR_APP_START     = 8'h0c;
  localparam logic [7:0] ADDR_APP_SIZE      = 8'h0d;
  localparam logic [7:0] ADDR_HASH_ENTRY    = 8'h10;
  localparam logic [7:0] ADDR_SYSCALL_ENTRY = 8'h12;
  localparam logic [7:0] ADDR_CDI_FIRST     = 8'h20;
  localparam logic [7:0] ADDR_CDI_LAST      = 8'h27;
  localparam logic [7:0] ADDR_MON_CTRL      = 8'h60;
  localparam logic [7:0] ADDR_MON_FIRST     = 8'h61;
  localparam logic [7:0] ADDR_MON_LAST      = 8'h62;

  // Identity words, ASCII "tk1 " and "mkdf"
  localparam logic [31:0] TK1_NAME0   = 32'h746B3120;
  localparam logic [31:0] TK1_NAME1   = 32'h6d6b6466;
  localparam logic [31:0] TK1_VERSION = 32'h00000005;

  // ----------------------------------------------------------
  // Memory-map limits
  // ----------------------------------------------------------
  localparam logic [31:0] FW_RAM_FIRST = 32'hd0000000;
  localparam logic [31:0] FW_RAM_LAST  = 32'hd00007ff;
  // ROM starts at address zero
  localparam logic [31:0] FW_ROM_LAST  = 32'h00001fff;
  // Outside physical memory, so a jump here traps
  localparam logic [31:0] ILLEGAL_ADDR = 32'h4f000000;

  // Sizes and reset values
  localparam logic [31:0] APP_SIZE_RESET  = 32'h0;
  localparam logic [2:0]  LED_RESET       = 3'h6;
  localparam int          TRAP_BLINK_BITS = 24;
  localparam int          CDI_WORDS       = 8;

  // ----------------------------------------------------------
  // Shared types
  // ----------------------------------------------------------
  typedef enum logic [3:0] {
    SEL_NONE,
    SEL_NAME0,
    SEL_NAME1,
    SEL_VERSION,
    SEL_MODE,
    SEL_LED,
    SEL_GPIO,
    SEL_APP_START,
    SEL_APP_SIZE,
    SEL_HASH,
    SEL_SYSCALL,
    SEL_CDI,
    SEL_MON_CTRL,
    SEL_MON_FIRST,
    SEL_MON_LAST
  } reg_sel_e;

  // Entry points and execution window seen by the security monitor
  typedef struct packed {
    logic [31:0] syscall_entry;
    logic [31:0] hash_entry;
    logic        mon_en;
    logic [31:0] mon_first;
    logic [31:0] mon_last;
  } exec_cfg_t;

endpackage

`default_nettype wire

// ==== hdl/tk1_reg_if.sv ====
// Interface tk1_reg_if with decoder and block modports for decoded register accesses
`timescale 1ns/1ps
`default_nettype none

interface tk1_reg_if
  import tk1_pkg::*;
();

  // Register targeted by the current access
  reg_sel_e    sel;
  // Write strobe, already cleared for refused privileged writes
  logic        wr;
  // Word index inside the CDI store
  logic [2:0]  widx;
  logic [31:0] wdata;

  // ----------------------------------------------------------
  // Views
  // ----------------------------------------------------------
  modport decoder (
    output sel,
    output wr,
    output widx,
    output wdata
  );

  modport block (
    input sel,
    input wr,
    input widx,
    input wdata
  );

endinterface

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the tk1_ctrl testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=build
LOG_FILE=sim.log

verilator --binary --timing -j 0 \
  --timescale 1ns/1ps \
  --top-module tb_tk1_core \
  -Mdir "$BUILD_DIR" \
  -f tk1_ctrl.f

"./$BUILD_DIR/Vtb_tk1_core" | tee "$LOG_FILE"

if grep -q "FAIL: see errors above" "$LOG_FILE"; then
  echo "Simulation failed, see $LOG_FILE"
  exit 1
fi
echo "Simulation finished without errors"

// ==== tk1_ctrl.f ====
hdl/tk1_pkg.sv
hdl/tk1_reg_if.sv
hdl/tk1_bus_decode.sv
hdl/tk1_cfg_regs.sv
hdl/tk1_exec_monitor.sv
hdl/tk1_led_gpio.sv
hdl/tk1_core.sv
dv/tk1_checker.sv
dv/tb_tk1_core.sv
